// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := tb_soc
RTL_TOP    := soc_top
FILELIST   := compile.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+source
source/bus_pkg.sv
source/periph_pkg.sv
source/bus_arbiter.sv
source/mem_interconnect.sv
source/ram.sv
source/sys_regs.sv
source/uart.sv
source/soc_top.sv
testbench/tb_soc.sv

// ==== source/bus_arbiter.sv ====
module bus_arbiter (
    input  logic                 pll_clk,
    input  logic                 rst_n,
    input  bus_pkg::instr_req_t  instr_req,
    input  bus_pkg::mem_req_t    data_req,
    input  bus_pkg::mem_rsp_t    mem_rsp,
    output bus_pkg::mem_rsp_t    instr_rsp,
    output bus_pkg::mem_rsp_t    data_rsp,
    output bus_pkg::mem_req_t    mem_req
);

    typedef enum logic [1:0] {
        grant_none,
        grant_instr,
        grant_data
    } grant_t;

    grant_t grant_q;
    grant_t grant;

    // new grant only when idle, data first
    always_comb begin
        grant = grant_q;
        if (grant_q == grant_none) begin
            if (data_req.read || data_req.write)
                grant = grant_data;
            else if (instr_req.read)
                grant = grant_instr;
        end
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n)
            grant_q <= grant_none;
        else
            grant_q <= mem_rsp.ready ? grant_none : grant;
    end

    always_comb begin
        mem_req = '0;
        case (grant)
            grant_data:  mem_req = data_req;
            grant_instr: begin
                mem_req.address = instr_req.address;
                mem_req.read    = instr_req.read;   // mask and write stay 0
            end
            default: ;
        endcase
    end

    always_comb begin
        instr_rsp = '0;
        data_rsp  = '0;
        if (grant == grant_instr)
            instr_rsp = mem_rsp;
        if (grant == grant_data)
            data_rsp = mem_rsp;
    end

    // owner must hold its request until the slave answers
    a_req_held: assert property (@(posedge pll_clk) disable iff (!rst_n)
        (grant != grant_none && !mem_rsp.ready) |=> $stable(mem_req))
        else $error("bus request changed before ready");

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // fetch port, read only
    typedef struct packed {
        logic [31:0] address;
        logic        read;
    } instr_req_t;

    // data port and common bus
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [3:0]  write_mask;
        logic [31:0] write_value;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] read_value;
        logic        ready;     // one cycle per transfer
    } mem_rsp_t;

endpackage

// ==== source/mem_interconnect.sv ====
`include "soc_params.svh"

module mem_interconnect (
    input  bus_pkg::mem_req_t  mem_req,
    input  bus_pkg::mem_rsp_t  ram_rsp,
    input  bus_pkg::mem_rsp_t  led_rsp,
    input  bus_pkg::mem_rsp_t  timer_rsp,
    input  bus_pkg::mem_rsp_t  uart_rsp,
    output bus_pkg::mem_rsp_t  mem_rsp,
    output logic               ram_sel,
    output logic               led_sel,
    output logic               timer_sel,
    output logic               uart_sel
);

    localparam int win_lsb = `SOC_WIN_BITS;

    logic                     active;
    logic [31-win_lsb:0]      page;
    periph_pkg::slave_sel_t   sel;

    assign active = mem_req.read || mem_req.write;
    assign page   = mem_req.address[31:win_lsb];

    always_comb begin
        sel = periph_pkg::sel_none;
        if (active) begin
            if (page == (`SOC_RAM_BASE >> win_lsb))
                sel = periph_pkg::sel_ram;
            else if (page == (`SOC_LED_BASE >> win_lsb))
                sel = periph_pkg::sel_led;
            else if (page == (`SOC_UART_BASE >> win_lsb))
                sel = periph_pkg::sel_uart;
            else if (page == (`SOC_TIMER_BASE >> win_lsb))
                sel = periph_pkg::sel_timer;
        end
    end

    assign ram_sel   = (sel == periph_pkg::sel_ram);
    assign led_sel   = (sel == periph_pkg::sel_led);
    assign timer_sel = (sel == periph_pkg::sel_timer);
    assign uart_sel  = (sel == periph_pkg::sel_uart);

    always_comb begin
        // unselected slaves drive zero
        mem_rsp.read_value = ram_rsp.read_value | led_rsp.read_value
                           | timer_rsp.read_value | uart_rsp.read_value;
        case (sel)
            periph_pkg::sel_ram:   mem_rsp.ready = ram_rsp.ready;
            periph_pkg::sel_led:   mem_rsp.ready = led_rsp.ready;
            periph_pkg::sel_timer: mem_rsp.ready = timer_rsp.ready;
            periph_pkg::sel_uart:  mem_rsp.ready = uart_rsp.ready;
            default:               mem_rsp.ready = active;  // unmapped, done at once
        endcase
    end

endmodule

// ==== source/periph_pkg.sv ====
package periph_pkg;

    typedef enum logic [2:0] {
        sel_none,
        sel_ram,
        sel_led,
        sel_uart,
        sel_timer
    } slave_sel_t;

    typedef struct packed {
        logic tx_busy;
        logic rx_valid;
    } uart_status_t;

    // register offsets, address[3:0]
    localparam logic [3:0] uart_data_ofs   = 4'h0;
    localparam logic [3:0] uart_status_ofs = 4'h4;
    localparam logic [3:0] timer_low_ofs   = 4'h0;
    localparam logic [3:0] timer_high_ofs  = 4'h4;

endpackage

// ==== source/ram.sv ====
`include "soc_params.svh"

module ram (
    input  logic               pll_clk,
    input  logic               rst_n,
    input  logic               sel,
    input  bus_pkg::mem_req_t  mem_req,
    output bus_pkg::mem_rsp_t  rsp
);

    localparam int addr_bits = $clog2(`SOC_RAM_WORDS);

    logic [31:0]          mem [`SOC_RAM_WORDS];
    logic [addr_bits-1:0] index;
    logic                 wait_q;     // first cycle of an access seen
    logic [31:0]          rdata_q;

    assign index = mem_req.address[addr_bits+1:2];

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n)
            wait_q <= 1'b0;
        else
            wait_q <= sel && !wait_q;
    end

    always_ff @(posedge pll_clk) begin
        if (sel && !wait_q)
            rdata_q <= mem[index];
        if (sel && wait_q && mem_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.write_mask[b])
                    mem[index][8*b +: 8] <= mem_req.write_value[8*b +: 8];
            end
        end
    end

    assign rsp.ready      = sel && wait_q;
    assign rsp.read_value = rsp.ready ? rdata_q : 32'b0;

endmodule

// ==== source/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ram depth in 32-bit words
`define SOC_RAM_WORDS 1024

// pll_clk cycles per serial bit
`define SOC_UART_DIV 16

// address map, each window decoded on address[31:16]
`define SOC_WIN_BITS 16

`define SOC_RAM_BASE   32'h0000_0000
`define SOC_LED_BASE   32'h0001_0000
`define SOC_UART_BASE  32'h0002_0000
`define SOC_TIMER_BASE 32'h0003_0000

`endif

// ==== source/soc_top.sv ====
module soc_top (
    input  logic                 pll_clk,
    input  logic                 rst_n,
    input  bus_pkg::instr_req_t  instr_req,
    input  bus_pkg::mem_req_t    data_req,
    input  logic                 uart_rx,
    output bus_pkg::mem_rsp_t    instr_rsp,
    output bus_pkg::mem_rsp_t    data_rsp,
    output logic [7:0]           leds,
    output logic                 uart_tx
);

    bus_pkg::mem_req_t mem_req;
    bus_pkg::mem_rsp_t mem_rsp;
    bus_pkg::mem_rsp_t ram_rsp;
    bus_pkg::mem_rsp_t led_rsp;
    bus_pkg::mem_rsp_t timer_rsp;
    bus_pkg::mem_rsp_t uart_rsp;

    logic ram_sel;
    logic led_sel;
    logic timer_sel;
    logic uart_sel;

    bus_arbiter u_bus_arbiter (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .data_req  (data_req),
        .mem_rsp   (mem_rsp),
        .instr_rsp (instr_rsp),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req)
    );

    mem_interconnect u_mem_interconnect (
        .mem_req   (mem_req),
        .ram_rsp   (ram_rsp),
        .led_rsp   (led_rsp),
        .timer_rsp (timer_rsp),
        .uart_rsp  (uart_rsp),
        .mem_rsp   (mem_rsp),
        .ram_sel   (ram_sel),
        .led_sel   (led_sel),
        .timer_sel (timer_sel),
        .uart_sel  (uart_sel)
    );

    ram u_ram (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .sel     (ram_sel),
        .mem_req (mem_req),
        .rsp     (ram_rsp)
    );

    sys_regs u_sys_regs (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .led_sel   (led_sel),
        .timer_sel (timer_sel),
        .mem_req   (mem_req),
        .led_rsp   (led_rsp),
        .timer_rsp (timer_rsp),
        .leds      (leds)
    );

    uart u_uart (
        .pll_clk (pll_clk),
        .rst_n   (rst_n),
        .sel     (uart_sel),
        .mem_req (mem_req),
        .uart_rx (uart_rx),
        .rsp     (uart_rsp),
        .uart_tx (uart_tx)
    );

endmodule

// ==== source/sys_regs.sv ====
module sys_regs (
    input  logic               pll_clk,
    input  logic               rst_n,
    input  logic               led_sel,
    input  logic               timer_sel,
    input  bus_pkg::mem_req_t  mem_req,
    output bus_pkg::mem_rsp_t  led_rsp,
    output bus_pkg::mem_rsp_t  timer_rsp,
    output logic [7:0]         leds
);

    logic [7:0]  led_q;
    logic [63:0] cycle_q;
    logic [31:0] high_q;    // high word captured with the low read
    logic [3:0]  offset;

    assign offset = mem_req.address[3:0];
    assign leds   = led_q;

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            led_q   <= 8'b0;
            cycle_q <= 64'b0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
            if (led_sel && mem_req.write && mem_req.write_mask[0])
                led_q <= mem_req.write_value[7:0];
        end
    end

    always_ff @(posedge pll_clk) begin
        if (timer_sel && mem_req.read && offset == periph_pkg::timer_low_ofs)
            high_q <= cycle_q[63:32];
    end

    always_comb begin
        led_rsp.ready      = led_sel;
        led_rsp.read_value = led_sel ? {24'b0, led_q} : 32'b0;
    end

    always_comb begin
        timer_rsp.ready      = timer_sel;
        timer_rsp.read_value = 32'b0;
        if (timer_sel) begin
            case (offset)
                periph_pkg::timer_low_ofs:  timer_rsp.read_value = cycle_q[31:0];
                periph_pkg::timer_high_ofs: timer_rsp.read_value = high_q;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/uart.sv ====
`include "soc_params.svh"

module uart (
    input  logic               pll_clk,
    input  logic               rst_n,
    input  logic               sel,
    input  bus_pkg::mem_req_t  mem_req,
    input  logic               uart_rx,
    output bus_pkg::mem_rsp_t  rsp,
    output logic               uart_tx
);

    localparam int div   = `SOC_UART_DIV;
    localparam int div_w = $clog2(div);

    logic [3:0]  offset;
    logic        tx_start;
    logic        rx_read;

    logic             tx_busy_q;
    logic [8:0]       tx_shift_q;   // data then stop
    logic [div_w-1:0] tx_div_q;
    logic [3:0]       tx_cnt_q;

    logic             rx_meta_q;
    logic             rx_sync_q;
    logic             rx_active_q;
    logic [div_w-1:0] rx_div_q;
    logic [3:0]       rx_cnt_q;
    logic [7:0]       rx_shift_q;
    logic [7:0]       rx_data_q;
    logic             rx_valid_q;

    periph_pkg::uart_status_t status;

    assign offset   = mem_req.address[3:0];
    assign tx_start = sel && mem_req.write && mem_req.write_mask[0]
                    && offset == periph_pkg::uart_data_ofs && !tx_busy_q;
    assign rx_read  = sel && mem_req.read && offset == periph_pkg::uart_data_ofs;

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy_q <= 1'b0;
            uart_tx   <= 1'b1;
            tx_div_q  <= '0;
            tx_cnt_q  <= 4'd0;
        end else if (tx_start) begin
            tx_busy_q  <= 1'b1;
            uart_tx    <= 1'b0;                 // start bit
            tx_shift_q <= {1'b1, mem_req.write_value[7:0]};
            tx_div_q   <= '0;
            tx_cnt_q   <= 4'd0;
        end else if (tx_busy_q) begin
            if (tx_div_q == div_w'(div - 1)) begin
                tx_div_q <= '0;
                if (tx_cnt_q == 4'd9) begin     // stop bit done
                    tx_busy_q <= 1'b0;
                    uart_tx   <= 1'b1;
                end else begin
                    uart_tx    <= tx_shift_q[0];
                    tx_shift_q <= {1'b1, tx_shift_q[8:1]};
                    tx_cnt_q   <= tx_cnt_q + 4'd1;
                end
            end else begin
                tx_div_q <= tx_div_q + 1'b1;
            end
        end
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta_q   <= 1'b1;
            rx_sync_q   <= 1'b1;
            rx_active_q <= 1'b0;
            rx_div_q    <= '0;
            rx_cnt_q    <= 4'd0;
            rx_valid_q  <= 1'b0;
        end else begin
            rx_meta_q <= uart_rx;
            rx_sync_q <= rx_meta_q;
            if (rx_read)
                rx_valid_q <= 1'b0;
            if (!rx_active_q) begin
                if (!rx_sync_q) begin
                    rx_active_q <= 1'b1;
                    rx_div_q    <= div_w'(div / 2);   // first sample mid start bit
                    rx_cnt_q    <= 4'd0;
                end
            end else if (rx_div_q == div_w'(div - 1)) begin
                rx_div_q <= '0;
                rx_cnt_q <= rx_cnt_q + 4'd1;
                if (rx_cnt_q == 4'd0 && rx_sync_q) begin
                    rx_active_q <= 1'b0;        // glitch, not a start bit
                end else if (rx_cnt_q == 4'd9) begin
                    rx_active_q <= 1'b0;
                    if (rx_sync_q) begin
                        rx_data_q  <= rx_shift_q;
                        rx_valid_q <= 1'b1;     // overwrites an unread byte
                    end
                end
            end else begin
                rx_div_q <= rx_div_q + 1'b1;
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (rx_active_q && rx_div_q == div_w'(div - 1) && rx_cnt_q != 4'd0)
            rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};   // lsb first
    end

    assign status.tx_busy  = tx_busy_q;
    assign status.rx_valid = rx_valid_q;

    always_comb begin
        rsp.ready      = sel;
        rsp.read_value = 32'b0;
        if (sel) begin
            case (offset)
                periph_pkg::uart_data_ofs:   rsp.read_value = {24'b0, rx_data_q};
                periph_pkg::uart_status_ofs: rsp.read_value = {30'b0, status};
                default: ;
            endcase
        end
    end

    a_tx_idle_high: assert property (@(posedge pll_clk) disable iff (!rst_n)
        !tx_busy_q |-> uart_tx)
        else $error("uart_tx low while transmitter idle");

endmodule

// ==== testbench/tb_soc.sv ====
`include "soc_params.svh"

module tb_soc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_half  = 20;
    localparam int chk_none  = 0;
    localparam int chk_value = 1;
    localparam int chk_timer = 2;
    localparam int ram_slots = 8;
    localparam logic [31:0] flash_window = 32'h2000_0000;
    // about 4 cycles per bus access, plus one serial frame and margin
    localparam int cycle_limit = 16 + (3 * ram_slots + 12) * 4 + 10 * `SOC_UART_DIV + 200;

    logic                pll_clk;
    logic                rst_n;
    logic                uart_rx;
    logic                uart_tx;
    logic [7:0]          leds;
    bus_pkg::instr_req_t instr_req;
    bus_pkg::mem_req_t   data_req;
    bus_pkg::mem_rsp_t   instr_rsp;
    bus_pkg::mem_rsp_t   data_rsp;

    logic [31:0] ram_model [`SOC_RAM_WORDS];
    int          slots [ram_slots];
    logic        bus_started;
    logic        data_open;     // data issued together with a fetch
    int          data_check;
    logic [31:0] data_expect;
    logic [31:0] instr_expect;
    logic [31:0] timer_last;
    logic        tx_expect;
    int          value_reads;
    int          timer_reads;
    int          fetches;
    int          cycles;

    soc_top dut (
        .pll_clk   (pll_clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .data_req  (data_req),
        .uart_rx   (uart_rx),
        .instr_rsp (instr_rsp),
        .data_rsp  (data_rsp),
        .leds      (leds),
        .uart_tx   (uart_tx)
    );

    assign uart_rx = uart_tx;   // serial loop-back

    always #clk_half pll_clk = ~pll_clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] value,
                                                input logic [3:0]  mask);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                merged[8*b +: 8] = value[8*b +: 8];
        end
        return merged;
    endfunction

    task automatic data_access(input logic write, input logic [31:0] address,
                               input logic [3:0] mask, input logic [31:0] value,
                               input int check, input logic [31:0] exp_value,
                               output logic [31:0] rdata);
        @(negedge pll_clk);
        bus_started          = 1'b1;
        data_check           = check;
        data_expect          = exp_value;
        data_req.address     = address;
        data_req.read        = !write;
        data_req.write       = write;
        data_req.write_mask  = mask;
        data_req.write_value = value;
        #(clk_half / 2);                // mid low phase, ready settled
        while (!data_rsp.ready) begin
            @(negedge pll_clk);
            #(clk_half / 2);
        end
        rdata = data_rsp.read_value;
        @(posedge pll_clk);             // transfer ends here
        @(negedge pll_clk);
        data_req   = '0;
        data_check = chk_none;
        if (check == chk_value)
            value_reads++;
        if (check == chk_timer)
            timer_reads++;
    endtask

    task automatic fetch_word(input int word_index);
        @(negedge pll_clk);
        bus_started       = 1'b1;
        instr_expect      = ram_model[word_index];
        instr_req.address = 32'(word_index) << 2;
        instr_req.read    = 1'b1;
        #(clk_half / 2);
        while (!instr_rsp.ready) begin
            @(negedge pll_clk);
            #(clk_half / 2);
        end
        @(posedge pll_clk);
        @(negedge pll_clk);
        instr_req = '0;
        fetches++;
    endtask

    task automatic ram_write(input int word_index, input logic [3:0] mask,
                             input logic [31:0] value);
        logic [31:0] unused_read;
        data_access(1'b1, 32'(word_index) << 2, mask, value, chk_none, 32'h0, unused_read);
        ram_model[word_index] = merge_bytes(ram_model[word_index], value, mask);
    endtask

    task automatic ram_read(input int word_index);
        logic [31:0] rd;
        data_access(1'b0, 32'(word_index) << 2, 4'h0, 32'h0, chk_value,
                    ram_model[word_index], rd);
    endtask

    // expected line level, one frame bit every SOC_UART_DIV cycles
    task automatic expect_frame(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};    // stop, data, start
        for (int k = 0; k < 10; k++) begin
            tx_expect = frame[k];
            repeat (`SOC_UART_DIV) @(negedge pll_clk);
        end
        tx_expect = 1'b1;
    endtask

    a_reset_idle: assert property (@(posedge pll_clk) disable iff (!rst_n)
        !bus_started |-> (!instr_rsp.ready && !data_rsp.ready && leds == 8'h00 && uart_tx))
        else report_failure($sformatf("ERR %0t: outputs not idle after reset", $time));

    a_data_value: assert property (@(posedge pll_clk) disable iff (!rst_n)
        (data_rsp.ready && data_req.read && data_check == chk_value)
        |-> data_rsp.read_value == data_expect)
        else report_failure($sformatf("ERR %0t: data read 0x%08h, expected 0x%08h", $time,
                            $sampled(data_rsp.read_value), $sampled(data_expect)));

    a_timer_rise: assert property (@(posedge pll_clk) disable iff (!rst_n)
        (data_rsp.ready && data_check == chk_timer) |-> data_rsp.read_value > timer_last)
        else report_failure($sformatf("ERR %0t: timer read 0x%08h, not above 0x%08h", $time,
                            $sampled(data_rsp.read_value), $sampled(timer_last)));

    a_instr_value: assert property (@(posedge pll_clk) disable iff (!rst_n)
        instr_rsp.ready |-> instr_rsp.read_value == instr_expect)
        else report_failure($sformatf("ERR %0t: fetch read 0x%08h, expected 0x%08h", $time,
                            $sampled(instr_rsp.read_value), $sampled(instr_expect)));

    a_data_first: assert property (@(posedge pll_clk) disable iff (!rst_n)
        instr_rsp.ready |-> !data_open)
        else report_failure($sformatf("ERR %0t: fetch finished before data", $time));

    a_led_drive: assert property (@(posedge pll_clk) disable iff (!rst_n)
        (data_rsp.ready && data_req.write && data_req.address == `SOC_LED_BASE
         && data_req.write_mask[0]) |=> leds == $past(data_req.write_value[7:0]))
        else report_failure($sformatf("ERR %0t: leds 0x%02h after write", $time,
                            $sampled(leds)));

    a_tx_line: assert property (@(posedge pll_clk) disable iff (!rst_n)
        uart_tx == tx_expect)
        else report_failure($sformatf("ERR %0t: uart_tx %0b, expected %0b", $time,
                            $sampled(uart_tx), $sampled(tx_expect)));

    always @(posedge pll_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
            report_failure($sformatf("simulation timed out after %0d cycles", cycles));
    end

    initial begin
        logic [31:0]              rd;
        logic [7:0]               led_value;
        logic [7:0]               tx_byte;
        periph_pkg::uart_status_t status_exp;
        pll_clk      = 1'b0;
        rst_n        = 1'b0;
        instr_req    = '0;
        data_req     = '0;
        bus_started  = 1'b0;
        data_open    = 1'b0;
        data_check   = chk_none;
        data_expect  = 32'h0;
        instr_expect = 32'h0;
        timer_last   = 32'h0;
        tx_expect    = 1'b1;
        value_reads  = 0;
        timer_reads  = 0;
        fetches      = 0;
        cycles       = 0;
        void'($urandom(12051));

        repeat (16) @(posedge pll_clk);
        @(negedge pll_clk);
        rst_n = 1'b1;
        repeat (4) @(negedge pll_clk);      // idle outputs watched here

        for (int i = 0; i < ram_slots; i++) begin
            slots[i] = int'($urandom % `SOC_RAM_WORDS);
            ram_write(slots[i], 4'hf, $urandom);
        end
        for (int i = 0; i < ram_slots; i++)
            ram_write(slots[$urandom % ram_slots], 4'($urandom), $urandom);
        for (int i = 0; i < ram_slots; i++)
            ram_read(slots[i]);

        data_open = 1'b1;
        fork
            begin
                ram_read(slots[0]);
                data_open = 1'b0;
            end
            fetch_word(slots[1]);
        join

        led_value = 8'($urandom);
        data_access(1'b1, `SOC_LED_BASE, 4'hf, {24'($urandom), led_value},
                    chk_none, 32'h0, rd);
        data_access(1'b0, `SOC_LED_BASE, 4'h0, 32'h0, chk_value, {24'h0, led_value}, rd);
        for (int i = 0; i < 3; i++) begin
            data_access(1'b0, `SOC_TIMER_BASE + 32'(periph_pkg::timer_low_ofs), 4'h0,
                        32'h0, chk_timer, 32'h0, rd);
            timer_last = rd;
        end

        tx_byte = 8'($urandom);
        data_access(1'b1, `SOC_UART_BASE + 32'(periph_pkg::uart_data_ofs), 4'h1,
                    {24'h0, tx_byte}, chk_none, 32'h0, rd);
        expect_frame(tx_byte);
        status_exp.tx_busy  = 1'b0;
        status_exp.rx_valid = 1'b1;
        data_access(1'b0, `SOC_UART_BASE + 32'(periph_pkg::uart_status_ofs), 4'h0, 32'h0,
                    chk_value, 32'(status_exp), rd);
        data_access(1'b0, `SOC_UART_BASE + 32'(periph_pkg::uart_data_ofs), 4'h0, 32'h0,
                    chk_value, {24'h0, tx_byte}, rd);
        data_access(1'b0, `SOC_UART_BASE + 32'(periph_pkg::uart_status_ofs), 4'h0, 32'h0,
                    chk_value, 32'h0, rd);  // rx_valid cleared by the data read

        data_access(1'b0, flash_window, 4'h0, 32'h0, chk_value, 32'h0, rd);

        if (value_reads > 0 && timer_reads > 0 && fetches > 0) begin
            $display("test passed");
            $finish;
        end else begin
            report_failure("not every check was reached");
        end
    end

endmodule
